/* rtl/tile_config.svh */
`ifndef TILE_CONFIG_SVH
`define TILE_CONFIG_SVH

// frame geometry in clocks per line and lines per frame
`define H_TOTAL      1041
`define V_TOTAL      666

// active window, first column and width, first and last line
`define H_ACT_START  1
`define H_ACT        800
`define V_ACT_FIRST  63
`define V_ACT_LAST   662

// sync pulses, both active high before the pin inversion
`define HS_START     861
`define HS_LEN       120
`define VS_START     35
`define VS_LEN       6

// width of each color pin group
`define PIN_BITS     3

// host byte address width
`define HOST_AW      15

// host address map
`define PIC_BASE     32'h0000
`define CHR_BASE     32'h1000
`define PAL_BASE     32'h2000
`define REG_BASE     32'h2800

// region sizes in bytes
`define PIC_BYTES    4096
`define CHR_BYTES    4096
`define PAL_BYTES    2048
`define REG_BYTES    2048

// palette depth in 16-bit entries
`define PAL_ENTRIES  1024

`endif

/* rtl/tile_pkg.sv */
package tile_pkg;

  // 5 bits per channel, red in the top bits
  typedef struct packed {
    logic [4:0] r;
    logic [4:0] g;
    logic [4:0] b;
  } rgb15_t;

  // bit 15 set means show the background color
  typedef struct packed {
    logic   transp;
    rgb15_t color;
  } pal_entry_t;

  typedef logic [7:0] glyph_t;
  typedef logic [8:0] coord9_t;

  // offsets inside the register region
  typedef enum logic [2:0] {
    REG_SCROLLX_LO = 3'd0,
    REG_SCROLLX_HI = 3'd1,
    REG_SCROLLY_LO = 3'd2,
    REG_SCROLLY_HI = 3'd3,
    REG_BG_LO      = 3'd4,
    REG_BG_HI      = 3'd5,
    REG_DITHER     = 3'd6
  } reg_addr_e;

  typedef enum logic [2:0] {
    REGION_PIC,
    REGION_CHR,
    REGION_PAL,
    REGION_REG,
    REGION_NONE
  } region_e;

endpackage

/* rtl/vga_timing.sv */
`timescale 1ns/10ps
`include "tile_config.svh"

module vga_timing import tile_pkg::*;
(
  input  logic    vga_clk,
  input  logic    rst_n_i,
  output coord9_t lx_o,
  output coord9_t ly_o,
  output logic    sx0_o,
  output logic    sy0_o,
  output logic    active_o,
  output logic    hs_o,
  output logic    vs_o
);

  logic [10:0] cnt_x;
  logic [9:0]  cnt_y;
  logic        x_last;
  logic        y_last;
  logic [10:0] col_rel;
  logic [9:0]  row_rel;

  assign x_last = (cnt_x == 11'(`H_TOTAL - 1));
  assign y_last = (cnt_y == 10'(`V_TOTAL - 1));

  // screen position relative to the top left active pixel
  assign col_rel = cnt_x - 11'(`H_ACT_START);
  assign row_rel = cnt_y - 10'(`V_ACT_FIRST);

  always_ff @(posedge vga_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      cnt_x    <= '0;
      cnt_y    <= '0;
      active_o <= 1'b0;
      hs_o     <= 1'b0;
      vs_o     <= 1'b0;
    end
    else
    begin
      cnt_x <= x_last ? 11'd0 : cnt_x + 11'd1;
      if (x_last)
        cnt_y <= y_last ? 10'd0 : cnt_y + 10'd1;
      hs_o     <= (cnt_x >= 11'(`HS_START)) && (cnt_x < 11'(`HS_START + `HS_LEN));
      vs_o     <= (cnt_y >= 10'(`VS_START)) && (cnt_y < 10'(`VS_START + `VS_LEN));
      active_o <= (cnt_x >= 11'(`H_ACT_START)) && (cnt_x < 11'(`H_ACT_START + `H_ACT))
                  && (cnt_y >= 10'(`V_ACT_FIRST)) && (cnt_y <= 10'(`V_ACT_LAST));
    end
  end

  // each logical pixel covers a 2x2 block of screen pixels
  always_ff @(posedge vga_clk)
  begin
    lx_o  <= col_rel[9:1];
    ly_o  <= row_rel[9:1];
    sx0_o <= col_rel[0];
    sy0_o <= row_rel[0];
  end

  // hsync sits entirely inside the horizontal blanking
  a_hs_blank: assert property (@(posedge vga_clk) disable iff (!rst_n_i)
    !(hs_o && active_o));

endmodule

/* rtl/host_regs.sv */
`timescale 1ns/10ps
`include "tile_config.svh"

module host_regs import tile_pkg::*;
(
  input  logic               vga_clk,
  input  logic               rst_n_i,
  input  logic               host_wr_i,
  input  logic [`HOST_AW-1:0] host_addr_i,
  input  logic [7:0]         host_data_i,
  output logic               pic_we_o,
  output logic               chr_we_o,
  output logic               pal_we_o,
  output logic [11:0]        wr_addr_o,
  output logic [7:0]         wr_data_o,
  output coord9_t            scroll_x_o,
  output coord9_t            scroll_y_o,
  output rgb15_t             bg_color_o,
  output logic               dither_en_o
);

  region_e              region;
  reg_addr_e            reg_sel;
  logic [`HOST_AW-1:0]  reg_off;
  logic                 reg_hit;
  logic [3:0]           region_hit;

  function automatic logic in_region(input logic [`HOST_AW-1:0] addr,
                                     input int unsigned base,
                                     input int unsigned len);
    logic [`HOST_AW-1:0] off;
    off = addr - base[`HOST_AW-1:0];
    return off < len[`HOST_AW-1:0];
  endfunction

  // one range hit per region of the address map
  assign region_hit[0] = in_region(host_addr_i, `PIC_BASE, `PIC_BYTES);
  assign region_hit[1] = in_region(host_addr_i, `CHR_BASE, `CHR_BYTES);
  assign region_hit[2] = in_region(host_addr_i, `PAL_BASE, `PAL_BYTES);
  assign region_hit[3] = in_region(host_addr_i, `REG_BASE, `REG_BYTES);

  always_comb
  begin
    if (region_hit[0])
      region = REGION_PIC;
    else if (region_hit[1])
      region = REGION_CHR;
    else if (region_hit[2])
      region = REGION_PAL;
    else if (region_hit[3])
      region = REGION_REG;
    else
      region = REGION_NONE;
  end

  // only the first eight offsets of the register page decode
  assign reg_off = host_addr_i - `HOST_AW'(`REG_BASE);
  assign reg_hit = (region == REGION_REG) && (reg_off[`HOST_AW-1:3] == '0);
  assign reg_sel = reg_addr_e'(reg_off[2:0]);

  assign pic_we_o  = host_wr_i && (region == REGION_PIC);
  assign chr_we_o  = host_wr_i && (region == REGION_CHR);
  assign pal_we_o  = host_wr_i && (region == REGION_PAL);
  assign wr_addr_o = host_addr_i[11:0];
  assign wr_data_o = host_data_i;

  always_ff @(posedge vga_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      scroll_x_o  <= '0;
      scroll_y_o  <= '0;
      bg_color_o  <= '0;
      dither_en_o <= 1'b1;
    end
    else if (host_wr_i && reg_hit)
    begin
      case (reg_sel)
        REG_SCROLLX_LO: scroll_x_o[7:0]  <= host_data_i;
        REG_SCROLLX_HI: scroll_x_o[8]    <= host_data_i[0];
        REG_SCROLLY_LO: scroll_y_o[7:0]  <= host_data_i;
        REG_SCROLLY_HI: scroll_y_o[8]    <= host_data_i[0];
        REG_BG_LO:      bg_color_o[7:0]  <= host_data_i;
        REG_BG_HI:      bg_color_o[14:8] <= host_data_i[6:0];
        REG_DITHER:     dither_en_o      <= host_data_i[0];
        default:        ;
      endcase
    end
  end

  // a host write lands in at most one region of the address map
  a_one_region: assert property (@(posedge vga_clk) disable iff (!rst_n_i)
    host_wr_i |-> $onehot0(region_hit));

endmodule

/* rtl/tile_fetch.sv */
`timescale 1ns/10ps
`include "tile_config.svh"

module tile_fetch import tile_pkg::*;
(
  input  logic        vga_clk,
  input  logic        rst_n_i,
  input  coord9_t     lx_i,
  input  coord9_t     ly_i,
  input  coord9_t     scroll_x_i,
  input  coord9_t     scroll_y_i,
  input  logic        pic_we_i,
  input  logic [11:0] wr_addr_i,
  input  logic [7:0]  wr_data_i,
  input  logic        sx0_i,
  input  logic        sy0_i,
  input  logic        active_i,
  input  logic        hs_i,
  input  logic        vs_i,
  output glyph_t      glyph_o,
  output logic [2:0]  row_o,
  output logic [2:0]  col_o,
  output logic        sx0_o,
  output logic        sy0_o,
  output logic        active_o,
  output logic        hs_o,
  output logic        vs_o
);

  glyph_t      pic_mem [`PIC_BYTES];
  coord9_t     col_s;
  coord9_t     row_s;
  logic [11:0] pic_addr;

  // 9-bit sums wrap at 512, the map is 64 tiles of 8 pixels
  assign col_s    = lx_i + scroll_x_i;
  assign row_s    = ly_i + scroll_y_i;
  assign pic_addr = {row_s[8:3], col_s[8:3]};

  always_ff @(posedge vga_clk)
  begin
    if (pic_we_i)
      pic_mem[wr_addr_i] <= wr_data_i;
    glyph_o <= pic_mem[pic_addr];
    row_o   <= row_s[2:0];
    col_o   <= col_s[2:0];
    sx0_o   <= sx0_i;
    sy0_o   <= sy0_i;
  end

  always_ff @(posedge vga_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      active_o <= 1'b0;
      hs_o     <= 1'b0;
      vs_o     <= 1'b0;
    end
    else
    begin
      active_o <= active_i;
      hs_o     <= hs_i;
      vs_o     <= vs_i;
    end
  end

endmodule

/* rtl/glyph_fetch.sv */
`timescale 1ns/10ps
`include "tile_config.svh"

module glyph_fetch import tile_pkg::*;
(
  input  logic        vga_clk,
  input  logic        rst_n_i,
  input  glyph_t      glyph_i,
  input  logic [2:0]  row_i,
  input  logic [2:0]  col_i,
  input  logic        chr_we_i,
  input  logic [11:0] wr_addr_i,
  input  logic [7:0]  wr_data_i,
  input  logic        sx0_i,
  input  logic        sy0_i,
  input  logic        active_i,
  input  logic        hs_i,
  input  logic        vs_i,
  output glyph_t      glyph_o,
  output logic [1:0]  pix_o,
  output logic        sx0_o,
  output logic        sy0_o,
  output logic        active_o,
  output logic        hs_o,
  output logic        vs_o
);

  logic [7:0]  chr_mem [`CHR_BYTES];
  logic [7:0]  chr_q;
  logic [1:0]  pix_sel_q;
  logic [11:0] chr_addr;

  // 16 bytes per glyph, two bytes per row of 8 pixels
  assign chr_addr = {glyph_i, row_i, col_i[2]};

  always_ff @(posedge vga_clk)
  begin
    if (chr_we_i)
      chr_mem[wr_addr_i] <= wr_data_i;
    chr_q     <= chr_mem[chr_addr];
    pix_sel_q <= col_i[1:0];
    glyph_o   <= glyph_i;
    sx0_o     <= sx0_i;
    sy0_o     <= sy0_i;
  end

  // leftmost pixel sits in the top two bits
  assign pix_o = chr_q[3'd6 - {pix_sel_q, 1'b0} +: 2];

  always_ff @(posedge vga_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      active_o <= 1'b0;
      hs_o     <= 1'b0;
      vs_o     <= 1'b0;
    end
    else
    begin
      active_o <= active_i;
      hs_o     <= hs_i;
      vs_o     <= vs_i;
    end
  end

endmodule

/* rtl/char_palette.sv */
`timescale 1ns/10ps
`include "tile_config.svh"

module char_palette import tile_pkg::*;
(
  input  logic        vga_clk,
  input  logic        rst_n_i,
  input  glyph_t      glyph_i,
  input  logic [1:0]  pix_i,
  input  rgb15_t      bg_color_i,
  input  logic        pal_we_i,
  input  logic [11:0] wr_addr_i,
  input  logic [7:0]  wr_data_i,
  input  logic        sx0_i,
  input  logic        sy0_i,
  input  logic        active_i,
  input  logic        hs_i,
  input  logic        vs_i,
  output rgb15_t      color_o,
  output logic        sx0_o,
  output logic        sy0_o,
  output logic        active_o,
  output logic        hs_o,
  output logic        vs_o
);

  pal_entry_t pal_mem [`PAL_ENTRIES];
  pal_entry_t pal_q;
  logic [9:0] pal_rd_idx;
  logic [9:0] pal_wr_idx;

  // four entries per glyph
  assign pal_rd_idx = {glyph_i, pix_i};
  assign pal_wr_idx = wr_addr_i[10:1];

  always_ff @(posedge vga_clk)
  begin
    if (pal_we_i)
    begin
      // byte lanes, low byte at the even address
      if (wr_addr_i[0])
        pal_mem[pal_wr_idx][15:8] <= wr_data_i;
      else
        pal_mem[pal_wr_idx][7:0] <= wr_data_i;
    end
    pal_q <= pal_mem[pal_rd_idx];
    sx0_o <= sx0_i;
    sy0_o <= sy0_i;
  end

  assign color_o = pal_q.transp ? bg_color_i : pal_q.color;

  always_ff @(posedge vga_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      active_o <= 1'b0;
      hs_o     <= 1'b0;
      vs_o     <= 1'b0;
    end
    else
    begin
      active_o <= active_i;
      hs_o     <= hs_i;
      vs_o     <= vs_i;
    end
  end

endmodule

/* rtl/pixel_out.sv */
`timescale 1ns/10ps
`include "tile_config.svh"

module pixel_out import tile_pkg::*;
(
  input  logic                 vga_clk,
  input  logic                 rst_n_i,
  input  rgb15_t               color_i,
  input  logic                 dither_en_i,
  input  logic                 sx0_i,
  input  logic                 sy0_i,
  input  logic                 active_i,
  input  logic                 hs_i,
  input  logic                 vs_i,
  output logic [`PIN_BITS-1:0] vga_red_o,
  output logic [`PIN_BITS-1:0] vga_green_o,
  output logic [`PIN_BITS-1:0] vga_blue_o,
  output logic                 vga_hsync_n_o,
  output logic                 vga_vsync_n_o
);

  logic [1:0]           dith;
  logic [`PIN_BITS-1:0] f_r;
  logic [`PIN_BITS-1:0] f_g;
  logic [`PIN_BITS-1:0] f_b;

  // add the threshold, then keep the top bits or clamp on carry
  function automatic logic [`PIN_BITS-1:0] dither_ch(input logic [4:0] ch,
                                                     input logic [1:0] d);
    logic [5:0] sum;
    sum = {1'b0, ch} + {4'b0, d};
    return sum[5] ? '1 : sum[4:2];
  endfunction

  // 2x2 pattern
  //   0 2
  //   3 1
  assign dith = {sx0_i ^ sy0_i, sy0_i} & {2{dither_en_i}};

  assign f_r = dither_ch(color_i.r, dith);
  assign f_g = dither_ch(color_i.g, dith);
  assign f_b = dither_ch(color_i.b, dith);

  always_ff @(posedge vga_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      vga_red_o     <= '0;
      vga_green_o   <= '0;
      vga_blue_o    <= '0;
      vga_hsync_n_o <= 1'b1;
      vga_vsync_n_o <= 1'b1;
    end
    else
    begin
      vga_red_o     <= active_i ? f_r : '0;
      vga_green_o   <= active_i ? f_g : '0;
      vga_blue_o    <= active_i ? f_b : '0;
      vga_hsync_n_o <= ~hs_i;
      vga_vsync_n_o <= ~vs_i;
    end
  end

endmodule

/* rtl/tile_video_top.sv */
`timescale 1ns/10ps
`include "tile_config.svh"

module tile_video_top import tile_pkg::*;
(
  input  logic                 vga_clk,
  input  logic                 rst_n_i,
  input  logic                 host_wr_i,
  input  logic [`HOST_AW-1:0]  host_addr_i,
  input  logic [7:0]           host_data_i,
  output logic [`PIN_BITS-1:0] vga_red_o,
  output logic [`PIN_BITS-1:0] vga_green_o,
  output logic [`PIN_BITS-1:0] vga_blue_o,
  output logic                 vga_hsync_n_o,
  output logic                 vga_vsync_n_o
);

  // host side
  logic        pic_we;
  logic        chr_we;
  logic        pal_we;
  logic [11:0] wr_addr;
  logic [7:0]  wr_data;
  coord9_t     scroll_x;
  coord9_t     scroll_y;
  rgb15_t      bg_color;
  logic        dither_en;

  // timing stage
  coord9_t     lx;
  coord9_t     ly;
  logic        v_sx0, v_sy0, v_active, v_hs, v_vs;

  // tile fetch stage
  glyph_t      t_glyph;
  logic [2:0]  t_row;
  logic [2:0]  t_col;
  logic        t_sx0, t_sy0, t_active, t_hs, t_vs;

  // glyph fetch stage
  glyph_t      g_glyph;
  logic [1:0]  g_pix;
  logic        g_sx0, g_sy0, g_active, g_hs, g_vs;

  // palette stage
  rgb15_t      p_color;
  logic        p_sx0, p_sy0, p_active, p_hs, p_vs;

  host_regs u_host_regs (
    .vga_clk     (vga_clk),
    .rst_n_i     (rst_n_i),
    .host_wr_i   (host_wr_i),
    .host_addr_i (host_addr_i),
    .host_data_i (host_data_i),
    .pic_we_o    (pic_we),
    .chr_we_o    (chr_we),
    .pal_we_o    (pal_we),
    .wr_addr_o   (wr_addr),
    .wr_data_o   (wr_data),
    .scroll_x_o  (scroll_x),
    .scroll_y_o  (scroll_y),
    .bg_color_o  (bg_color),
    .dither_en_o (dither_en)
  );

  vga_timing u_vga_timing (
    .vga_clk  (vga_clk),
    .rst_n_i  (rst_n_i),
    .lx_o     (lx),
    .ly_o     (ly),
    .sx0_o    (v_sx0),
    .sy0_o    (v_sy0),
    .active_o (v_active),
    .hs_o     (v_hs),
    .vs_o     (v_vs)
  );

  tile_fetch u_tile_fetch (
    .vga_clk    (vga_clk),
    .rst_n_i    (rst_n_i),
    .lx_i       (lx),
    .ly_i       (ly),
    .scroll_x_i (scroll_x),
    .scroll_y_i (scroll_y),
    .pic_we_i   (pic_we),
    .wr_addr_i  (wr_addr),
    .wr_data_i  (wr_data),
    .sx0_i      (v_sx0),
    .sy0_i      (v_sy0),
    .active_i   (v_active),
    .hs_i       (v_hs),
    .vs_i       (v_vs),
    .glyph_o    (t_glyph),
    .row_o      (t_row),
    .col_o      (t_col),
    .sx0_o      (t_sx0),
    .sy0_o      (t_sy0),
    .active_o   (t_active),
    .hs_o       (t_hs),
    .vs_o       (t_vs)
  );

  glyph_fetch u_glyph_fetch (
    .vga_clk   (vga_clk),
    .rst_n_i   (rst_n_i),
    .glyph_i   (t_glyph),
    .row_i     (t_row),
    .col_i     (t_col),
    .chr_we_i  (chr_we),
    .wr_addr_i (wr_addr),
    .wr_data_i (wr_data),
    .sx0_i     (t_sx0),
    .sy0_i     (t_sy0),
    .active_i  (t_active),
    .hs_i      (t_hs),
    .vs_i      (t_vs),
    .glyph_o   (g_glyph),
    .pix_o     (g_pix),
    .sx0_o     (g_sx0),
    .sy0_o     (g_sy0),
    .active_o  (g_active),
    .hs_o      (g_hs),
    .vs_o      (g_vs)
  );

  char_palette u_char_palette (
    .vga_clk    (vga_clk),
    .rst_n_i    (rst_n_i),
    .glyph_i    (g_glyph),
    .pix_i      (g_pix),
    .bg_color_i (bg_color),
    .pal_we_i   (pal_we),
    .wr_addr_i  (wr_addr),
    .wr_data_i  (wr_data),
    .sx0_i      (g_sx0),
    .sy0_i      (g_sy0),
    .active_i   (g_active),
    .hs_i       (g_hs),
    .vs_i       (g_vs),
    .color_o    (p_color),
    .sx0_o      (p_sx0),
    .sy0_o      (p_sy0),
    .active_o   (p_active),
    .hs_o       (p_hs),
    .vs_o       (p_vs)
  );

  pixel_out u_pixel_out (
    .vga_clk       (vga_clk),
    .rst_n_i       (rst_n_i),
    .color_i       (p_color),
    .dither_en_i   (dither_en),
    .sx0_i         (p_sx0),
    .sy0_i         (p_sy0),
    .active_i      (p_active),
    .hs_i          (p_hs),
    .vs_i          (p_vs),
    .vga_red_o     (vga_red_o),
    .vga_green_o   (vga_green_o),
    .vga_blue_o    (vga_blue_o),
    .vga_hsync_n_o (vga_hsync_n_o),
    .vga_vsync_n_o (vga_vsync_n_o)
  );

endmodule

/* verif/tb_tile_video.sv */
`timescale 1ns/10ps
`include "tile_config.svh"

module tb_tile_video import tile_pkg::*;
();

  // one frame to fill and lock, four checked frames, one frame of margin
  localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
  localparam int MAX_CYCLES   = 6 * FRAME_CYCLES;

  logic                 vga_clk;
  logic                 rst_n_i;
  logic                 host_wr_i;
  logic [`HOST_AW-1:0]  host_addr_i;
  logic [7:0]           host_data_i;
  logic [`PIN_BITS-1:0] vga_red_o;
  logic [`PIN_BITS-1:0] vga_green_o;
  logic [`PIN_BITS-1:0] vga_blue_o;
  logic                 vga_hsync_n_o;
  logic                 vga_vsync_n_o;

  // mirrors of everything written to the DUT
  logic [7:0] pic_m [`PIC_BYTES];
  logic [7:0] chr_m [`CHR_BYTES];
  logic [7:0] pal_m [`PAL_BYTES];
  int         scroll_x_m = 0;
  int         scroll_y_m = 0;
  int         bg_m = 0;
  int         dither_m = 1;

  // pin position tracker
  int   px = 0;
  int   py = 0;
  logic h_locked = 1'b0;
  logic v_locked = 1'b0;
  logic hs_prev = 1'b1;
  logic vs_prev = 1'b1;
  int   hs_low = 0;
  int   vs_low = 0;
  logic check_en = 1'b0;
  int   cycle_cnt = 0;

  tile_video_top dut_i (
    .vga_clk       (vga_clk),
    .rst_n_i       (rst_n_i),
    .host_wr_i     (host_wr_i),
    .host_addr_i   (host_addr_i),
    .host_data_i   (host_data_i),
    .vga_red_o     (vga_red_o),
    .vga_green_o   (vga_green_o),
    .vga_blue_o    (vga_blue_o),
    .vga_hsync_n_o (vga_hsync_n_o),
    .vga_vsync_n_o (vga_vsync_n_o)
  );

  initial
  begin
    vga_clk = 1'b0;
    forever #50 vga_clk = ~vga_clk;
  end

  task automatic check_value(input string name, input int actual, input int expected);
    if (actual != expected)
    begin
      $display("error at %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
      $display("TEST FAILED");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // expected {r, g, b} pins for screen column c and active line l
  function automatic int expected_rgb(input int c, input int l);
    int lx;
    int ly;
    int sx0;
    int sy0;
    int col_s;
    int row_s;
    int glyph;
    int line_byte;
    int pix_val;
    int entry;
    int color;
    int d;
    int ch;
    int result;
    lx    = c / 2;
    ly    = l / 2;
    sx0   = c % 2;
    sy0   = l % 2;
    col_s = (lx + scroll_x_m) % 512;
    row_s = (ly + scroll_y_m) % 512;
    glyph = int'(pic_m[12'((row_s / 8) * 64 + col_s / 8)]);
    line_byte = int'(chr_m[12'(glyph * 16 + (row_s % 8) * 2 + (col_s % 8) / 4)]);
    pix_val = (line_byte >> (6 - 2 * (col_s % 4))) % 4;
    entry = int'(pal_m[11'((glyph * 4 + pix_val) * 2)])
            + 256 * int'(pal_m[11'((glyph * 4 + pix_val) * 2 + 1)]);
    color = (entry >= 32768) ? bg_m : entry % 32768;
    d = (dither_m != 0) ? 2 * (sx0 ^ sy0) + sy0 : 0;
    result = 0;
    for (int s = 2; s >= 0; s--)
    begin
      ch = (color >> (5 * s)) % 32 + d;
      result = result * 8 + ((ch >= 32) ? 7 : ch / 4);
    end
    return result;
  endfunction

  task automatic check_pins();
    int   exp_rgb;
    logic in_window;
    in_window = (px >= `H_ACT_START) && (px < `H_ACT_START + `H_ACT)
                && (py >= `V_ACT_FIRST) && (py <= `V_ACT_LAST);
    check_value("vga_hsync_n_o", int'(vga_hsync_n_o),
                (px >= `HS_START && px < `HS_START + `HS_LEN) ? 0 : 1);
    check_value("vga_vsync_n_o", int'(vga_vsync_n_o),
                (py >= `VS_START && py < `VS_START + `VS_LEN) ? 0 : 1);
    if (!in_window || check_en)
    begin
      exp_rgb = in_window ? expected_rgb(px - `H_ACT_START, py - `V_ACT_FIRST) : 0;
      check_value("vga_red_o", int'(vga_red_o), (exp_rgb >> 6) % 8);
      check_value("vga_green_o", int'(vga_green_o), (exp_rgb >> 3) % 8);
      check_value("vga_blue_o", int'(vga_blue_o), exp_rgb % 8);
    end
  endtask

  // outputs change on the rising edge, so sample them on the falling one
  always @(negedge vga_clk)
  begin
    if (h_locked)
    begin
      if (px == `H_TOTAL - 1)
      begin
        px = 0;
        if (v_locked)
          py = (py == `V_TOTAL - 1) ? 0 : py + 1;
      end
      else
        px = px + 1;
    end
    if (!vga_hsync_n_o && hs_prev)
    begin
      if (h_locked)
        check_value("hsync_n fall column", px, `HS_START);
      px = `HS_START;
      h_locked = 1'b1;
    end
    if (!vga_vsync_n_o && vs_prev)
    begin
      if (v_locked)
        check_value("vsync_n fall line", py, `VS_START);
      check_value("vsync_n fall column", px, 0);
      py = `VS_START;
      v_locked = 1'b1;
    end
    // pulse widths
    if (!vga_hsync_n_o)
      hs_low = hs_low + 1;
    else if (!hs_prev)
    begin
      check_value("hsync_n low cycles", hs_low, `HS_LEN);
      hs_low = 0;
    end
    if (!vga_vsync_n_o)
      vs_low = vs_low + 1;
    else if (!vs_prev)
    begin
      check_value("vsync_n low cycles", vs_low, `VS_LEN * `H_TOTAL);
      vs_low = 0;
    end
    hs_prev = vga_hsync_n_o;
    vs_prev = vga_vsync_n_o;
    if (h_locked && v_locked)
      check_pins();
  end

  always @(posedge vga_clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES)
    begin
      $display("timeout: the frames did not complete within %0d cycles", MAX_CYCLES);
      $display("TEST FAILED");
      $fatal(1, "run limit reached");
    end
  end

  task automatic host_write(input int addr, input int data);
    @(negedge vga_clk);
    host_wr_i   = 1'b1;
    host_addr_i = addr[`HOST_AW-1:0];
    host_data_i = data[7:0];
  endtask

  task automatic host_release();
    @(negedge vga_clk);
    host_wr_i = 1'b0;
  endtask

  task automatic write_pic(input int idx, input int data);
    host_write(`PIC_BASE + idx, data);
    pic_m[12'(idx)] = data[7:0];
  endtask

  task automatic write_chr(input int idx, input int data);
    host_write(`CHR_BASE + idx, data);
    chr_m[12'(idx)] = data[7:0];
  endtask

  task automatic write_pal(input int idx, input int data);
    host_write(`PAL_BASE + idx, data);
    pal_m[11'(idx)] = data[7:0];
  endtask

  task automatic set_scroll(input int x, input int y);
    host_write(`REG_BASE + int'(REG_SCROLLX_LO), x % 256);
    host_write(`REG_BASE + int'(REG_SCROLLX_HI), x / 256);
    host_write(`REG_BASE + int'(REG_SCROLLY_LO), y % 256);
    host_write(`REG_BASE + int'(REG_SCROLLY_HI), y / 256);
    scroll_x_m = x;
    scroll_y_m = y;
  endtask

  task automatic set_bg(input int color);
    host_write(`REG_BASE + int'(REG_BG_LO), color % 256);
    host_write(`REG_BASE + int'(REG_BG_HI), color / 256);
    bg_m = color;
  endtask

  task automatic set_dither(input int en);
    host_write(`REG_BASE + int'(REG_DITHER), en);
    dither_m = en;
  endtask

  // random fill, palette entries start opaque
  task automatic fill_memories();
    for (int i = 0; i < `PIC_BYTES; i++)
      write_pic(i, int'($urandom % 256));
    for (int i = 0; i < `CHR_BYTES; i++)
      write_chr(i, int'($urandom % 256));
    for (int i = 0; i < `PAL_BYTES; i++)
      write_pal(i, (i % 2 == 1) ? int'($urandom % 128) : int'($urandom % 256));
  endtask

  task automatic mark_transparent(input int count);
    int entry;
    for (int n = 0; n < count; n++)
    begin
      entry = int'($urandom % `PAL_ENTRIES);
      write_pal(entry * 2 + 1, 128 + int'($urandom % 128));
    end
  endtask

  initial
  begin
    rst_n_i     = 1'b0;
    host_wr_i   = 1'b0;
    host_addr_i = '0;
    host_data_i = '0;
    void'($urandom(32'h3c13_769c));
    repeat (2) @(negedge vga_clk);
    rst_n_i = 1'b1;

    set_dither(0);
    fill_memories();
    host_release();

    // plain frame, no scroll
    @(negedge vga_vsync_n_o);
    check_en = 1'b1;
    @(negedge vga_vsync_n_o);

    // scroll written in vblank
    set_scroll(int'($urandom % 512), int'($urandom % 512));
    host_release();
    @(negedge vga_vsync_n_o);

    // transparent entries show the background
    set_bg(int'($urandom % 32768));
    mark_transparent(64);
    host_release();
    @(negedge vga_vsync_n_o);

    // white background drives the dithered sums into saturation
    set_bg(32767);
    set_dither(1);
    host_release();
    @(negedge vga_vsync_n_o);

    $display("TEST OK");
    $finish;
  end

endmodule

/* files.f */
+incdir+rtl
rtl/tile_pkg.sv
rtl/vga_timing.sv
rtl/host_regs.sv
rtl/tile_fetch.sv
rtl/glyph_fetch.sv
rtl/char_palette.sv
rtl/pixel_out.sv
rtl/tile_video_top.sv
verif/tb_tile_video.sv

/* run_sim.sh */
#!/bin/sh
# build the tile video testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f files.f --top-module tb_tile_video -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/Vtb_tile_video > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST OK$" "$LOG"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see $LOG"
  exit 1
fi
